//--- branch_cmd_regs.sv
// APB slave holding branch operands; each command write queues one branch request.
`timescale 1ns/1ns
`default_nettype none

module branch_cmd_regs
(
	input wire clock,
	input wire rst_n,
	input wire [7:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	input wire full,
	input wire [branch_pkg::count_width-1:0] count,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic push,
	output logic [branch_pkg::req_width-1:0] push_req
);
	import branch_pkg::*;

	logic [data_width-1:0] pc_reg;
	logic [data_width-1:0] source_reg;
	logic [flags_width-1:0] flags_reg;
	branch_cmd_e cmd_reg;
	branch_cc_e cc_reg;
	branch_cmd_e wr_cmd;
	branch_cc_e wr_cc;
	logic access;
	logic addr_hit;
	logic cmd_write;
	logic wr_done;

	assign access = psel && penable;
	assign cmd_write = access && pwrite && (paddr == reg_cmd);

	assign wr_cmd = branch_cmd_e'(pwdata[cmd_width-1:0]);
	assign wr_cc = branch_cc_e'(pwdata[8 +: cc_width]);

	always_comb
	begin
		case (paddr)
			reg_pc, reg_source, reg_flags, reg_cmd, reg_status:
				addr_hit = 1'b1;
			default:
				addr_hit = 1'b0;
		endcase
	end

	assign pready = access && !(cmd_write && full); // Stall command writes on a full queue.
	assign pslverr = access && (!addr_hit || (pwrite && (paddr == reg_status)));
	assign wr_done = pready && pwrite && !pslverr;

	assign push = cmd_write && !full;
	assign push_req = {wr_cmd, wr_cc, flags_reg, pc_reg, source_reg};

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			pc_reg <= '0;
			source_reg <= '0;
			flags_reg <= '0;
			cmd_reg <= exe_branch_bur;
			cc_reg <= cc_al;
		end
		else if (wr_done)
		begin
			case (paddr)
				reg_pc:
					pc_reg <= pwdata;
				reg_source:
					source_reg <= pwdata;
				reg_flags:
					flags_reg <= pwdata[flags_width-1:0];
				reg_cmd:
				begin
					cmd_reg <= wr_cmd; // Kept for read back.
					cc_reg <= wr_cc;
				end
				default:
					pc_reg <= pc_reg;
			endcase
		end
	end

	always_comb
	begin
		case (paddr)
			reg_pc:
				prdata = pc_reg;
			reg_source:
				prdata = source_reg;
			reg_flags:
				prdata = {{(32 - flags_width){1'b0}}, flags_reg};
			reg_cmd:
				prdata = {20'b0, cc_reg, 3'b0, cmd_reg};
			reg_status:
				prdata = {{(32 - count_width){1'b0}}, count}; // Queue occupancy.
			default:
				prdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- branch_execute.sv
// Branch evaluator: checks condition against flags, computes target, holds result under back-pressure.
`timescale 1ns/1ns
`default_nettype none

module branch_execute
(
	input wire clock,
	input wire rst_n,
	input wire pop_valid,
	input wire [branch_pkg::req_width-1:0] pop_req,
	input wire res_ready,
	output logic pop,
	output logic res_valid,
	output logic [31:0] res_addr,
	output logic res_jump,
	output logic res_not_jump,
	output logic res_intb,
	output logic res_halt
);
	import branch_pkg::*;

	branch_cmd_e req_cmd;
	branch_cc_e req_cc;
	logic [flags_width-1:0] req_flags;
	logic [data_width-1:0] req_pc;
	logic [data_width-1:0] req_source;
	logic [data_width-1:0] next_addr;
	logic normal_jump;
	logic cond_true;

	function automatic logic [data_width-1:0] func_branch_addr
	(
		input branch_cmd_e cmd,
		input logic [data_width-1:0] pc,
		input logic [data_width-1:0] source
	);
		case (cmd)
			exe_branch_bur, exe_branch_br:
				return pc + source;
			exe_branch_b:
				return source;
			default:
				return '0;
		endcase
	endfunction

	function automatic logic func_normal_jump(input branch_cmd_e cmd);
		return (cmd == exe_branch_bur) || (cmd == exe_branch_br) || (cmd == exe_branch_b);
	endfunction

	function automatic logic func_cond_check
	(
		input branch_cc_e cc,
		input logic [flags_width-1:0] flags
	);
		logic zf;
		logic sf;
		logic of;
		logic cf;
		logic pf;
		zf = flags[flags_zf];
		sf = flags[flags_sf];
		of = flags[flags_of];
		cf = flags[flags_cf];
		pf = flags[flags_pf];
		case (cc)
			cc_al:  return 1'b1;
			cc_eq:  return zf;
			cc_neq: return !zf;
			cc_mi:  return sf;
			cc_pl:  return !sf;
			cc_en:  return !pf; // Even parity.
			cc_on:  return pf;
			cc_ovf: return of;
			cc_ueo: return cf;
			cc_uu:  return !cf;
			cc_uo:  return cf && !zf;
			cc_ueu: return !cf || zf;
			cc_seo: return sf == of;
			cc_su:  return sf != of;
			cc_so:  return !((sf ^ of) || zf);
			cc_seu: return (sf ^ of) || zf;
			default: return 1'b1;
		endcase
	endfunction

	// Request fields.
	assign req_cmd = branch_cmd_e'(pop_req[req_cmd_lsb +: cmd_width]);
	assign req_cc = branch_cc_e'(pop_req[req_cc_lsb +: cc_width]);
	assign req_flags = pop_req[req_flags_lsb +: flags_width];
	assign req_pc = pop_req[req_pc_lsb +: data_width];
	assign req_source = pop_req[req_source_lsb +: data_width];

	assign next_addr = func_branch_addr(req_cmd, req_pc, req_source);
	assign normal_jump = func_normal_jump(req_cmd);
	assign cond_true = func_cond_check(req_cc, req_flags);

	// Take a new request when the result stage is empty or draining.
	assign pop = pop_valid && (!res_valid || res_ready);

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			res_valid <= 1'b0;
			res_jump <= 1'b0;
			res_not_jump <= 1'b0;
			res_intb <= 1'b0;
			res_halt <= 1'b0;
		end
		else if (pop)
		begin
			res_valid <= 1'b1;
			res_jump <= normal_jump && cond_true;
			res_not_jump <= normal_jump && !cond_true;
			res_intb <= (req_cmd == exe_branch_intb);
			res_halt <= (req_cmd == exe_branch_halt);
		end
		else if (res_ready)
		begin
			res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (pop)
		begin
			res_addr <= next_addr;
		end
	end

endmodule

`default_nettype wire

//--- branch_pkg.sv
// Branch unit shared types: opcodes, condition codes, flag bits, APB register map, request layout.
`default_nettype none

package branch_pkg;

	// Branch opcodes; values 5 to 31 are no-operation.
	typedef enum logic [4:0]
	{
		exe_branch_bur  = 5'd0,
		exe_branch_br   = 5'd1,
		exe_branch_b    = 5'd2,
		exe_branch_intb = 5'd3,
		exe_branch_halt = 5'd4
	} branch_cmd_e;

	typedef enum logic [3:0]
	{
		cc_al  = 4'd0,
		cc_eq  = 4'd1,
		cc_neq = 4'd2,
		cc_mi  = 4'd3,
		cc_pl  = 4'd4,
		cc_en  = 4'd5,
		cc_on  = 4'd6,
		cc_ovf = 4'd7,
		cc_ueo = 4'd8,
		cc_uu  = 4'd9,
		cc_uo  = 4'd10,
		cc_ueu = 4'd11,
		cc_seo = 4'd12,
		cc_su  = 4'd13,
		cc_so  = 4'd14,
		cc_seu = 4'd15
	} branch_cc_e;

	// Bit positions in the flag word.
	localparam int flags_pf = 0;
	localparam int flags_of = 1;
	localparam int flags_cf = 2;
	localparam int flags_sf = 3;
	localparam int flags_zf = 4;

	// APB register offsets.
	localparam logic [7:0] reg_pc     = 8'h00;
	localparam logic [7:0] reg_source = 8'h04;
	localparam logic [7:0] reg_flags  = 8'h08;
	localparam logic [7:0] reg_cmd    = 8'h0C;
	localparam logic [7:0] reg_status = 8'h10;

	localparam int queue_depth = 4;
	localparam int count_width = $clog2(queue_depth + 1);
	localparam int ptr_width   = $clog2(queue_depth);

	// Field widths of one request.
	localparam int cmd_width   = 5;
	localparam int cc_width    = 4;
	localparam int flags_width = 5;
	localparam int data_width  = 32;

	// Packed request, msb first: opcode, condition code, flags, pc, source.
	localparam int req_source_lsb = 0;
	localparam int req_pc_lsb     = req_source_lsb + data_width;
	localparam int req_flags_lsb  = req_pc_lsb + data_width;
	localparam int req_cc_lsb     = req_flags_lsb + flags_width;
	localparam int req_cmd_lsb    = req_cc_lsb + cc_width;
	localparam int req_width      = req_cmd_lsb + cmd_width;

endpackage

`default_nettype wire

//--- branch_queue.sv
// Four-entry FIFO of branch requests between the APB registers and the evaluator.
`timescale 1ns/1ns
`default_nettype none

module branch_queue
(
	input wire clock,
	input wire rst_n,
	input wire push,
	input wire [branch_pkg::req_width-1:0] push_req,
	input wire pop,
	output logic pop_valid,
	output logic [branch_pkg::req_width-1:0] pop_req,
	output logic full,
	output logic [branch_pkg::count_width-1:0] count
);
	import branch_pkg::*;

	localparam logic [ptr_width-1:0] last_ptr = ptr_width'(queue_depth - 1);

	logic [req_width-1:0] mem [queue_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;

	always_ff @(posedge clock)
	begin
		if (push)
		begin
			mem[wr_ptr] <= push_req;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
			begin
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			end
			if (pop)
			begin
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:
					count <= count + 1'b1;
				2'b01:
					count <= count - 1'b1;
				default:
					count <= count; // Both or neither.
			endcase
		end
	end

	assign pop_valid = (count != '0);
	assign full = (count == count_width'(queue_depth));
	assign pop_req = mem[rd_ptr]; // Head entry.

endmodule

`default_nettype wire

//--- branch_unit_assertions.sv
// Branch unit protocol checks on the APB port, the queue push and the result handshake.
`timescale 1ns/1ns
`default_nettype none

module branch_unit_assertions
(
	input wire clock,
	input wire rst_n,
	input wire psel,
	input wire penable,
	input wire pready,
	input wire push,
	input wire pop,
	input wire [branch_pkg::count_width-1:0] count,
	input wire res_valid,
	input wire res_ready,
	input wire [31:0] res_addr,
	input wire res_jump,
	input wire res_not_jump,
	input wire res_intb,
	input wire res_halt
);
	import branch_pkg::*;

	int failures = 0; // Failed assertions so far.

	apb_setup_first: assert property (@(posedge clock) disable iff (!rst_n)
		(penable && !$past(penable)) |-> $past(psel && !penable))
		else
		begin
			$error("APB access phase started without a setup cycle");
			failures++;
		end

	// An access in wait states keeps its select and enable.
	apb_access_held: assert property (@(posedge clock) disable iff (!rst_n)
		(psel && penable && !pready) |=> (psel && penable))
		else
		begin
			$error("APB access dropped while pready was low");
			failures++;
		end

	// A push without a pop adds one entry and never takes the queue past its depth.
	push_not_full: assert property (@(posedge clock) disable iff (!rst_n)
		(push && !pop) |=> ((count == $past(count) + 1'b1) && (count <= queue_depth)))
		else
		begin
			$error("Request push overran the queue or was not counted");
			failures++;
		end

	result_held: assert property (@(posedge clock) disable iff (!rst_n)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_addr)
			&& $stable({res_jump, res_not_jump, res_intb, res_halt})))
		else
		begin
			$error("Held result changed before res_ready");
			failures++;
		end

	// At most one outcome per result.
	jump_exclusive: assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0({res_jump, res_not_jump, res_intb, res_halt}))
		else
		begin
			$error("More than one result outcome high together");
			failures++;
		end

endmodule

bind branch_unit_top branch_unit_assertions branch_unit_assertions_i
(
	.clock(clock),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.push(push),
	.pop(pop),
	.count(count),
	.res_valid(res_valid),
	.res_ready(res_ready),
	.res_addr(res_addr),
	.res_jump(res_jump),
	.res_not_jump(res_not_jump),
	.res_intb(res_intb),
	.res_halt(res_halt)
);

`default_nettype wire

//--- branch_unit_tb.sv
// Branch unit testbench: APB stimulus, reference model of branch results and scoreboard.
`timescale 1ns/1ns
`default_nettype none

module branch_unit_tb;
	import branch_pkg::*;

	localparam int num_cmds = 400;
	localparam int stall_cmds = 6;
	localparam int timeout_cycles = num_cmds * 20 + 100;

	logic clock;
	logic rst_n;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	wire [31:0] prdata;
	wire pready;
	wire pslverr;
	wire res_valid;
	logic res_ready;
	wire [31:0] res_addr;
	wire res_jump;
	wire res_not_jump;
	wire res_intb;
	wire res_halt;
	logic [35:0] expected_q[$]; // Address, jump, not jump, intb, halt.
	logic [35:0] expected_now;
	logic [31:0] rd;
	logic err;
	int sent = 0;
	int results = 0;
	int mismatches = 0;
	int protocol_errors = 0;
	int assertion_failures = 0;
	int cycles = 0;
	int ready_mode = 0; // 0 random, 1 held low, 2 held high.
	int seed;

	branch_unit_top branch_unit_top_i (.*);

	always #4 clock = ~clock;

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles == timeout_cycles)
		begin
			$display("Timeout: not every command produced a result within %0d cycles", cycles);
			$display("** FAIL **");
			$finish;
		end
	end

	always @(posedge clock)
	begin
		case (ready_mode)
			1: res_ready <= 1'b0;
			2: res_ready <= 1'b1;
			default: res_ready <= ($urandom % 3) != 0; // Low about a third of the time.
		endcase
	end

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Error: %s expected %h actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	function automatic logic cond_holds(input logic [3:0] cc, input logic [4:0] f);
		logic zero;
		logic less;
		zero = f[flags_zf];
		less = f[flags_sf] ^ f[flags_of]; // Signed less than.
		case (cc)
			cc_al: return 1'b1;
			cc_eq: return zero;
			cc_neq: return !zero;
			cc_mi: return f[flags_sf];
			cc_pl: return !f[flags_sf];
			cc_en: return !f[flags_pf];
			cc_on: return f[flags_pf];
			cc_ovf: return f[flags_of];
			cc_ueo: return f[flags_cf];
			cc_uu: return !f[flags_cf];
			cc_uo: return f[flags_cf] && !zero;
			cc_ueu: return !f[flags_cf] || zero;
			cc_seo: return !less;
			cc_su: return less;
			cc_so: return !zero && !less;
			default: return less || zero;
		endcase
	endfunction

	function automatic logic [35:0] expected_result(input logic [4:0] op, input logic [3:0] cc,
		input logic [4:0] f, input logic [31:0] pc, input logic [31:0] src);
		logic [31:0] addr;
		logic branch_op;
		logic taken;
		branch_op = (op == exe_branch_bur) || (op == exe_branch_br) || (op == exe_branch_b);
		taken = cond_holds(cc, f);
		addr = (op == exe_branch_bur || op == exe_branch_br) ? pc + src
			: (op == exe_branch_b) ? src : 32'd0;
		return {addr, branch_op && taken, branch_op && !taken,
			op == exe_branch_intb, op == exe_branch_halt};
	endfunction

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic slverr);
		@(posedge clock);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clock);
		penable <= 1'b1;
		@(negedge clock);
		while (!pready)
			@(negedge clock);
		rdata = prdata;
		slverr = pslverr;
		@(posedge clock); // Completing edge.
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic slverr;
		apb_access(1'b1, addr, data, rdata, slverr);
		compare_field("pslverr", 32'd0, 32'(slverr));
	endtask

	task automatic read_reg(input logic [7:0] addr, input logic [31:0] expected);
		logic [31:0] rdata;
		logic slverr;
		apb_access(1'b0, addr, 32'd0, rdata, slverr);
		compare_field("prdata", expected, rdata);
		compare_field("pslverr", 32'd0, 32'(slverr));
	endtask

	task automatic send_command(input logic [4:0] op, input logic [3:0] cc, input logic [4:0] f,
		input logic [31:0] pc, input logic [31:0] src);
		write_reg(reg_pc, pc);
		write_reg(reg_source, src);
		write_reg(reg_flags, {27'b0, f});
		write_reg(reg_cmd, {20'b0, cc, 3'b0, op});
		expected_q.push_back(expected_result(op, cc, f, pc, src));
		sent++;
	endtask

	task automatic send_random(input logic [3:0] cc);
		logic [4:0] op;
		op = ($urandom % 4 == 0) ? 5'($urandom % 32) : 5'($urandom % 5);
		send_command(op, cc, 5'($urandom), $urandom, $urandom);
	endtask

	task automatic wait_drained();
		while (results < sent)
			@(posedge clock);
	endtask

	// Command write must stay in wait states while the queue is full.
	task automatic check_stall();
		@(negedge clock);
		while (!(psel && penable && paddr == reg_cmd))
			@(negedge clock);
		repeat (5)
		begin
			if (pready)
			begin
				$display("Command write completed while the queue was full");
				protocol_errors++;
			end
			@(negedge clock);
		end
		ready_mode = 2;
	endtask

	always @(negedge clock)
	begin
		if (rst_n && res_valid && res_ready)
		begin
			if (expected_q.size() == 0)
			begin
				$display("Result delivered with no command pending");
				protocol_errors++;
			end
			else
			begin
				expected_now = expected_q.pop_front();
				compare_field("res_addr", expected_now[35:4], res_addr);
				compare_field("res_jump", 32'(expected_now[3]), 32'(res_jump));
				compare_field("res_not_jump", 32'(expected_now[2]), 32'(res_not_jump));
				compare_field("res_intb", 32'(expected_now[1]), 32'(res_intb));
				compare_field("res_halt", 32'(expected_now[0]), 32'(res_halt));
				results++;
			end
		end
	end

	initial
	begin
		seed = $urandom(32'hf485e5b5);
		clock = 1'b0;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = 8'h00;
		pwdata = 32'd0;
		res_ready = 1'b0;
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		compare_field("res_valid", 32'd0, 32'(res_valid));
		read_reg(reg_status, 32'd0);
		read_reg(reg_pc, 32'd0);
		read_reg(reg_source, 32'd0);
		read_reg(reg_flags, 32'd0);
		read_reg(reg_cmd, 32'd0);
		for (int i = 0; i < num_cmds - stall_cmds; i++)
			send_random(4'(i)); // Walks all condition codes.
		wait_drained();
		ready_mode = 1;
		repeat (2) @(posedge clock);
		repeat (5) send_random(4'($urandom)); // One held result and a full queue.
		read_reg(reg_status, 32'd4);
		fork
			send_random(cc_al);
			check_stall();
		join
		ready_mode = 0;
		wait_drained();
		apb_access(1'b0, 8'h20, 32'd0, rd, err);
		compare_field("pslverr", 32'd1, 32'(err));
		apb_access(1'b1, reg_status, 32'd7, rd, err);
		compare_field("pslverr", 32'd1, 32'(err));
		read_reg(reg_status, 32'd0);
		assertion_failures = branch_unit_top_i.branch_unit_assertions_i.failures;
		$display("Errors: mismatches %0d, protocol %0d, assertions %0d, results %0d of %0d",
			mismatches, protocol_errors, assertion_failures, results, sent);
		if (mismatches == 0 && protocol_errors == 0 && assertion_failures == 0
			&& results == num_cmds)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- branch_unit_top.sv
// Branch unit top: APB command registers feeding the request queue and the branch evaluator.
`timescale 1ns/1ns
`default_nettype none

module branch_unit_top
(
	input wire clock,
	input wire rst_n,
	input wire [7:0] paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [31:0] pwdata,
	output wire [31:0] prdata,
	output wire pready,
	output wire pslverr,
	output wire res_valid,
	input wire res_ready,
	output wire [31:0] res_addr,
	output wire res_jump,
	output wire res_not_jump,
	output wire res_intb,
	output wire res_halt
);
	import branch_pkg::*;

	wire push;
	wire [req_width-1:0] push_req;
	wire pop;
	wire pop_valid;
	wire [req_width-1:0] pop_req;
	wire full;
	wire [count_width-1:0] count;

	branch_cmd_regs branch_cmd_regs_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.full(full),
		.count(count),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.push(push),
		.push_req(push_req)
	);

	branch_queue branch_queue_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.push(push),
		.push_req(push_req),
		.pop(pop),
		.pop_valid(pop_valid),
		.pop_req(pop_req),
		.full(full),
		.count(count)
	);

	branch_execute branch_execute_i
	(
		.clock(clock),
		.rst_n(rst_n),
		.pop_valid(pop_valid),
		.pop_req(pop_req),
		.res_ready(res_ready),
		.pop(pop),
		.res_valid(res_valid),
		.res_addr(res_addr),
		.res_jump(res_jump),
		.res_not_jump(res_not_jump),
		.res_intb(res_intb),
		.res_halt(res_halt)
	);

endmodule

`default_nettype wire

//--- project.f
branch_pkg.sv
branch_cmd_regs.sv
branch_queue.sv
branch_execute.sv
branch_unit_top.sv
branch_unit_assertions.sv
branch_unit_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -Wno-fatal --top-module branch_unit_tb \
		-f project.f -o branch_unit_sim \
	&& ./obj_dir/branch_unit_sim > sim.log 2>&1 \
	&& ! grep -qF "** FAIL **" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
